// ==== rtl/tex_pkg.sv ====
`default_nettype none

package tex_pkg;

    // ------------------------------------------------------------
    // Datapath widths
    // ------------------------------------------------------------
    localparam int coord_w  = 7;     // u and v
    localparam int addr_w   = 18;    // Word address and start register
    localparam int factor_w = 3;     // Row pitch as a power of two
    localparam int texel_w  = 8;
    localparam int word_w   = 32;    // Four texels per word
    localparam int sel_w    = 2;     // Texel within a word

    // ------------------------------------------------------------
    // Texel memory
    // ------------------------------------------------------------
    localparam int mem_depth = 4096;
    localparam int mem_aw    = $clog2(mem_depth);  // Low address bits used

    // Configuration register selector
    typedef enum logic [0:0] {
        reg_start  = 1'b0,
        reg_factor = 1'b1
    } cfg_reg_e;

endpackage

`default_nettype wire

// ==== rtl/tex_config_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

// Host-side registers steering the address mapper.
// One write strobe, one register selected per write.
module tex_config_regs
(
    input  logic                         clk,
    input  logic                         rst,

    // Host write port
    input  logic                         cfg_wr,
    input  tex_pkg::cfg_reg_e            cfg_sel,
    input  logic [tex_pkg::addr_w-1:0]   cfg_data,

    // To address mapper
    output logic [tex_pkg::addr_w-1:0]   start,
    output logic [tex_pkg::factor_w-1:0] factor
);

    // ------------------------------------------------------------
    // Start address register
    // ------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            start <= '0;
        end
        else if (cfg_wr && (cfg_sel == tex_pkg::reg_start))
        begin
            start <= cfg_data;
        end
    end

    // ------------------------------------------------------------
    // Pitch factor register
    // ------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            factor <= '0;
        end
        else if (cfg_wr && (cfg_sel == tex_pkg::reg_factor))
        begin
            factor <= cfg_data[tex_pkg::factor_w-1:0];  // Upper bits dropped
        end
    end

endmodule

`default_nettype wire

// ==== rtl/linear_map.sv ====
`timescale 1ns/1ps
`default_nettype none

module linear_map
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         req,
    input  logic [tex_pkg::coord_w-1:0]  u,
    input  logic [tex_pkg::coord_w-1:0]  v,
    input  logic [tex_pkg::addr_w-1:0]   start,
    input  logic [tex_pkg::factor_w-1:0] factor,
    output logic [tex_pkg::addr_w-1:0]   addr,
    output logic                         addr_valid,
    output logic [tex_pkg::sel_w-1:0]    texelselect
);

    localparam int pad_w = tex_pkg::addr_w - tex_pkg::coord_w;

    logic [tex_pkg::coord_w-1:0] u_q;
    logic [tex_pkg::coord_w-1:0] v_q;
    logic                        req_q;
    logic [tex_pkg::addr_w-1:0]  u_word;   // u / 4, zero extended
    logic [tex_pkg::addr_w-1:0]  v_ext;
    logic [tex_pkg::addr_w-1:0]  v_row;    // v times row pitch

    // ------------------------------------------------------------
    // Stage 1: coordinate capture
    // ------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (req)
        begin
            u_q <= u;
            v_q <= v;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            req_q <= 1'b0;
        else
            req_q <= req;
    end

    // ------------------------------------------------------------
    // Stage 2: row-pitched word address
    // ------------------------------------------------------------
    assign u_word = {{(pad_w + tex_pkg::sel_w){1'b0}}, u_q[tex_pkg::coord_w-1:tex_pkg::sel_w]};
    assign v_ext  = {{pad_w{1'b0}}, v_q};

    always_comb
    begin
        case (factor)
            3'd0: v_row = v_ext;
            3'd1: v_row = v_ext << 1;
            3'd2: v_row = v_ext << 2;
            3'd3: v_row = v_ext << 3;
            3'd4: v_row = v_ext << 4;
            3'd5: v_row = v_ext << 5;
            3'd6: v_row = v_ext << 6;
            3'd7: v_row = v_ext << 7;   // Widest pitch still fits in addr_w
        endcase
    end

    always_ff @(posedge clk)
    begin
        addr        <= start + u_word + v_row;  // Wraps at addr_w bits
        texelselect <= u_q[tex_pkg::sel_w-1:0];
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            addr_valid <= 1'b0;
        else
            addr_valid <= req_q;
    end

endmodule

`default_nettype wire

// ==== rtl/texel_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

// Texture word store. Host writes on one port, sampler reads on the other
module texel_memory
(
    input  logic                        clk,
    input  logic                        rst,

    // Host load port
    input  logic                        mem_wr,
    input  logic [tex_pkg::addr_w-1:0]  mem_addr,
    input  logic [tex_pkg::word_w-1:0]  mem_data,

    // Sampler read port
    input  logic [tex_pkg::addr_w-1:0]  addr,
    input  logic                        addr_valid,
    output logic [tex_pkg::word_w-1:0]  rd_data,
    output logic                        rd_valid
);

    logic [tex_pkg::word_w-1:0] mem [tex_pkg::mem_depth];

    logic [tex_pkg::mem_aw-1:0] wr_index;
    logic [tex_pkg::mem_aw-1:0] rd_index;

    // Addresses wrap modulo mem_depth
    assign wr_index = mem_addr[tex_pkg::mem_aw-1:0];
    assign rd_index = addr[tex_pkg::mem_aw-1:0];

    // ------------------------------------------------------------
    // Write port
    // ------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (mem_wr)
        begin
            mem[wr_index] <= mem_data;
        end
    end

    // ------------------------------------------------------------
    // Read port
    // ------------------------------------------------------------
    // Same-cycle write to the read address returns the old word
    always_ff @(posedge clk)
    begin
        if (addr_valid)
        begin
            rd_data <= mem[rd_index];
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rd_valid <= 1'b0;
        end
        else
        begin
            rd_valid <= addr_valid;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/texel_extract.sv ====
`timescale 1ns/1ps
`default_nettype none

module texel_extract
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic [tex_pkg::sel_w-1:0]   texelselect,
    input  logic [tex_pkg::word_w-1:0]  rd_data,
    input  logic                        rd_valid,
    output logic [tex_pkg::texel_w-1:0] texel,
    output logic                        texel_valid
);

    logic [tex_pkg::sel_w-1:0] sel_q;  // Aligned with rd_data

    // ------------------------------------------------------------
    // Select alignment
    // ------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        sel_q <= texelselect;   // Matches memory read latency
    end

    // ------------------------------------------------------------
    // Byte pick and output strobe
    // ------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (rd_valid)
        begin
            texel <= rd_data[sel_q*tex_pkg::texel_w +: tex_pkg::texel_w];  // Byte 0 lowest
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            texel_valid <= 1'b0;
        end
        else
        begin
            texel_valid <= rd_valid;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/tex_sampler.sv ====
`timescale 1ns/1ps
`default_nettype none

// Texture sampler top: config, address map, memory, byte extract.
// Fixed three-cycle latency from req to texel_valid
module tex_sampler
(
    input  logic                         clk,
    input  logic                         rst,

    // Configuration port
    input  logic                         cfg_wr,
    input  tex_pkg::cfg_reg_e            cfg_sel,
    input  logic [tex_pkg::addr_w-1:0]   cfg_data,

    // Memory load port
    input  logic                         mem_wr,
    input  logic [tex_pkg::addr_w-1:0]   mem_addr,
    input  logic [tex_pkg::word_w-1:0]   mem_data,

    // Sample request
    input  logic                         req,
    input  logic [tex_pkg::coord_w-1:0]  u,
    input  logic [tex_pkg::coord_w-1:0]  v,

    // Sample result
    output logic [tex_pkg::texel_w-1:0]  texel,
    output logic                         texel_valid
);

    logic [tex_pkg::addr_w-1:0]   start;
    logic [tex_pkg::factor_w-1:0] factor;
    logic [tex_pkg::addr_w-1:0]   addr;
    logic                         addr_valid;
    logic [tex_pkg::sel_w-1:0]    texelselect;
    logic [tex_pkg::word_w-1:0]   rd_data;
    logic                         rd_valid;

    // ------------------------------------------------------------
    // Configuration
    // ------------------------------------------------------------
    tex_config_regs tex_config_regs_inst (
        .clk      (clk),
        .rst      (rst),
        .cfg_wr   (cfg_wr),
        .cfg_sel  (cfg_sel),
        .cfg_data (cfg_data),
        .start    (start),
        .factor   (factor)
    );

    // ------------------------------------------------------------
    // Pipeline
    // ------------------------------------------------------------
    linear_map linear_map_inst (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .u           (u),
        .v           (v),
        .start       (start),
        .factor      (factor),
        .addr        (addr),
        .addr_valid  (addr_valid),
        .texelselect (texelselect)
    );

    texel_memory texel_memory_inst (
        .clk        (clk),
        .rst        (rst),
        .mem_wr     (mem_wr),
        .mem_addr   (mem_addr),
        .mem_data   (mem_data),
        .addr       (addr),
        .addr_valid (addr_valid),
        .rd_data    (rd_data),
        .rd_valid   (rd_valid)
    );

    texel_extract texel_extract_inst (
        .clk         (clk),
        .rst         (rst),
        .texelselect (texelselect),
        .rd_data     (rd_data),
        .rd_valid    (rd_valid),
        .texel       (texel),
        .texel_valid (texel_valid)
    );

endmodule

`default_nettype wire

// ==== sim/tb_tex_model.svh ====
`ifndef TB_TEX_MODEL_SVH
`define TB_TEX_MODEL_SVH

// ------------------------------------------------------------
// Reference state mirrored from the host writes
// ------------------------------------------------------------
logic [31:0]                  lfsr_state   = 32'h98a4_76a1;
logic [tex_pkg::word_w-1:0]   mem_model [tex_pkg::mem_depth];
logic [tex_pkg::addr_w-1:0]   start_model  = '0;
logic [tex_pkg::factor_w-1:0] factor_model = '0;

// Galois LFSR, x^32 + x^22 + x^2 + x + 1
function automatic logic lfsr_bit();
    logic out_bit;
    out_bit    = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out_bit)
        lfsr_state = lfsr_state ^ 32'h8020_0003;
    return out_bit;
endfunction

function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    int          i;
    r = '0;
    for (i = 0; i < n; i++)
        r = {r[30:0], lfsr_bit()};   // One step per bit
    return r;
endfunction

// Odd multiplier keeps every word address distinct
function automatic logic [tex_pkg::word_w-1:0] fill_word(input int a);
    return (a * 32'h9e37_79b1) ^ 32'h3c5a_a5c3;
endfunction

// ------------------------------------------------------------
// Address and byte rules
// ------------------------------------------------------------
function automatic int word_index(input int uu, input int vv);
    int row_offset;
    row_offset = vv * (1 << factor_model);   // Pitch is a power of two
    return (start_model + uu / 4 + row_offset) % (1 << tex_pkg::addr_w);
endfunction

function automatic logic [tex_pkg::texel_w-1:0] model_texel(input int uu, input int vv);
    logic [tex_pkg::word_w-1:0] word;
    word = mem_model[word_index(uu, vv) % tex_pkg::mem_depth];
    return word[(uu % 4) * 8 +: 8];   // Byte 0 in the low bits
endfunction

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (expected !== actual)
    begin
        $display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, expected, actual);
        fail_run("texel value mismatch");
    end
endtask

`endif

// ==== sim/tb_tex_sampler.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_tex_sampler;

    localparam int clk_period     = 40;
    localparam int preload_words  = tex_pkg::mem_depth;
    localparam int idle_cycles    = 10;
    localparam int drain_limit    = 10;
    localparam int sel_reqs       = 128;
    localparam int factor_reqs    = 16;
    localparam int start_rounds   = 8;
    localparam int start_reqs     = 16;
    localparam int burst_reqs     = 200;
    localparam int rewrite_rounds = 4;
    localparam int rewrite_words  = 16;
    localparam int watchdog_cycles = 8 + preload_words + idle_cycles + (1 + drain_limit)
        + (sel_reqs + drain_limit) + 8 * (1 + factor_reqs + drain_limit)
        + start_rounds * (2 + start_reqs + drain_limit) + (burst_reqs + drain_limit)
        + rewrite_rounds * (2 * rewrite_words + drain_limit) + 200;

    logic                         clk = 1'b0;
    logic                         rst;
    logic                         cfg_wr;
    tex_pkg::cfg_reg_e            cfg_sel;
    logic [tex_pkg::addr_w-1:0]   cfg_data;
    logic                         mem_wr;
    logic [tex_pkg::addr_w-1:0]   mem_addr;
    logic [tex_pkg::word_w-1:0]   mem_data;
    logic                         req;
    logic [tex_pkg::coord_w-1:0]  u;
    logic [tex_pkg::coord_w-1:0]  v;
    logic [tex_pkg::texel_w-1:0]  texel;
    logic                         texel_valid;

    logic [tex_pkg::texel_w-1:0]  exp_q [$];   // Scoreboard
    int                           edge_q [$];  // Request edge per entry
    int                           cycle_count = 0;
    string                        test_name = "reset";

    `include "tb_tex_model.svh"

    always #(clk_period / 2) clk = ~clk;

    always @(posedge clk)
        cycle_count <= cycle_count + 1;

    tex_sampler tex_sampler_inst (
        .clk         (clk),
        .rst         (rst),
        .cfg_wr      (cfg_wr),
        .cfg_sel     (cfg_sel),
        .cfg_data    (cfg_data),
        .mem_wr      (mem_wr),
        .mem_addr    (mem_addr),
        .mem_data    (mem_data),
        .req         (req),
        .u           (u),
        .v           (v),
        .texel       (texel),
        .texel_valid (texel_valid)
    );

    // ------------------------------------------------------------
    // Drive helpers
    // ------------------------------------------------------------
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic tick();
        @(posedge clk);
        #2;   // Drive point
    endtask

    task automatic write_cfg(input tex_pkg::cfg_reg_e sel, input logic [tex_pkg::addr_w-1:0] data);
        cfg_wr   = 1'b1;
        cfg_sel  = sel;
        cfg_data = data;
        if (sel == tex_pkg::reg_start)
            start_model = data;
        else
            factor_model = data[tex_pkg::factor_w-1:0];
        tick();
        cfg_wr = 1'b0;
    endtask

    task automatic write_word(input logic [tex_pkg::addr_w-1:0] waddr,
                              input logic [tex_pkg::word_w-1:0] wdata);
        mem_wr   = 1'b1;
        mem_addr = waddr;
        mem_data = wdata;
        mem_model[waddr % tex_pkg::mem_depth] = wdata;
        tick();
        mem_wr = 1'b0;
    endtask

    task automatic send_req(input int uu, input int vv);
        req = 1'b1;
        u   = uu;
        v   = vv;
        exp_q.push_back(model_texel(uu, vv));
        edge_q.push_back(cycle_count + 1);   // Sampled at the next edge
        tick();
        req = 1'b0;
    endtask

    task automatic send_random_req();
        int uu;
        int vv;
        uu = rand_bits(tex_pkg::coord_w);
        vv = rand_bits(tex_pkg::coord_w);
        send_req(uu, vv);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < drain_limit)
        begin
            tick();
            waited++;
        end
        if (exp_q.size() != 0)
            fail_run("texel_valid never arrived for an outstanding request");
    endtask

    // ------------------------------------------------------------
    // Result monitor
    // ------------------------------------------------------------
    always @(negedge clk)
    begin : monitor
        logic [tex_pkg::texel_w-1:0] exp_texel;
        int                          req_edge;
        if (!rst && texel_valid)
        begin
            if (exp_q.size() == 0)
                fail_run("texel_valid seen with no request outstanding");
            else
            begin
                exp_texel = exp_q.pop_front();
                req_edge  = edge_q.pop_front();
                if (cycle_count != req_edge + 3)
                    fail_run("texel_valid did not arrive 3 cycles after its request");
                else
                    check_value(test_name, exp_texel, texel);
            end
        end
    end

    initial
    begin : watchdog
        #(watchdog_cycles * clk_period);
        fail_run("Watchdog timeout: the run took longer than its tests allow");
    end

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial
    begin : main
        int                         i;
        int                         r;
        int                         f;
        int                         fixed_v;
        int                         ru [rewrite_words];
        int                         rv [rewrite_words];
        logic [tex_pkg::addr_w-1:0] waddr;
        rst      = 1'b1;
        cfg_wr   = 1'b0;
        cfg_sel  = tex_pkg::reg_start;
        cfg_data = '0;
        mem_wr   = 1'b0;
        mem_addr = '0;
        mem_data = '0;
        req      = 1'b0;
        u        = '0;
        v        = '0;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;

        test_name = "preload_idle";
        for (i = 0; i < preload_words; i++)
        begin
            waddr = (rand_bits(6) << 12) | i;   // Upper bits must be ignored
            write_word(waddr, fill_word(i));
        end
        repeat (idle_cycles) tick();

        test_name = "reset_defaults";
        send_random_req();
        drain();

        test_name = "texel_select";
        fixed_v = rand_bits(tex_pkg::coord_w);
        for (i = 0; i < sel_reqs; i++)
            send_req(i, fixed_v);
        drain();

        test_name = "pitch_factor";
        for (f = 0; f < 8; f++)
        begin
            write_cfg(tex_pkg::reg_factor, (rand_bits(15) << 3) | f);
            for (i = 0; i < factor_reqs; i++)
                send_random_req();
            drain();
        end

        test_name = "start_register";
        for (r = 0; r < start_rounds; r++)
        begin
            if (r % 2 == 0)
                waddr = 18'h3ffff - rand_bits(8);   // Sum wraps past the top
            else
                waddr = rand_bits(tex_pkg::addr_w);
            write_cfg(tex_pkg::reg_start, waddr);
            write_cfg(tex_pkg::reg_factor, rand_bits(tex_pkg::factor_w));
            for (i = 0; i < start_reqs; i++)
                send_random_req();
            drain();
        end

        test_name = "back_to_back";
        for (i = 0; i < burst_reqs; i++)
            send_random_req();
        drain();

        test_name = "memory_rewrite";
        for (r = 0; r < rewrite_rounds; r++)
        begin
            for (i = 0; i < rewrite_words; i++)
            begin
                ru[i] = rand_bits(tex_pkg::coord_w);
                rv[i] = rand_bits(tex_pkg::coord_w);
                waddr = word_index(ru[i], rv[i]);
                write_word(waddr, rand_bits(tex_pkg::word_w));
            end
            for (i = 0; i < rewrite_words; i++)
                send_req(ru[i], rv[i]);
            drain();
        end

        if (exp_q.size() != 0)
            fail_run("Requests still outstanding at the end of the run");
        else
        begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== tex_sampler.f ====
+incdir+sim
rtl/tex_pkg.sv
rtl/tex_config_regs.sv
rtl/linear_map.sv
rtl/texel_memory.sv
rtl/texel_extract.sv
rtl/tex_sampler.sv
sim/tb_tex_sampler.sv
